// File: design/mastermind_pkg.sv
package mastermind_pkg;

    localparam int PEGS = 4;

    // One peg colour, eight colours
    typedef logic [2:0] peg_t;

    // Peg 0 sits in the low bits
    typedef struct packed {
        peg_t [PEGS-1:0] peg;
    } row_t;

    typedef logic [2:0] count_t; // 0 to 4 pegs

    typedef struct packed {
        count_t red;
        count_t white;
    } score_t;

    typedef enum logic [1:0] {
        CODE_ENTRY,
        GUESS_ENTRY,
        SCORING,
        GAME_END
    } phase_t;

endpackage

// File: design/seven_seg_pkg.sv
package seven_seg_pkg;

    // Active low, segment a in bit 0
    typedef logic [6:0] segments_t;

    function automatic segments_t digit_segments(input logic [3:0] digit);
        case (digit)
            4'h0: return 7'b100_0000;
            4'h1: return 7'b111_1001;
            4'h2: return 7'b010_0100;
            4'h3: return 7'b011_0000;
            4'h4: return 7'b001_1001;
            4'h5: return 7'b001_0010;
            4'h6: return 7'b000_0010;
            4'h7: return 7'b111_1000;
            4'h8: return 7'b000_0000;
            4'h9: return 7'b001_1000;
            4'hA: return 7'b000_1000;
            4'hB: return 7'b000_0011;
            4'hC: return 7'b100_0110;
            4'hD: return 7'b010_0001;
            4'hE: return 7'b000_0110;
            4'hF: return 7'b000_1110;
            default: return 7'h7f; // Blank
        endcase
    endfunction

endpackage

// File: design/mastermind_entry.sv
`timescale 1ns/1ns

module mastermind_entry
    import mastermind_pkg::*;
#(
    parameter int MAX_GUESSES = 8
) (
    input  logic       clock,
    input  logic       resetn,
    input  logic       load_i,
    input  peg_t       colour_i,
    input  score_t     score_i,
    input  logic       done_i,
    output row_t       code_o,
    output row_t       guess_o,
    output logic       start_o,
    output logic       clear_o,
    output phase_t     phase_o,
    output logic [3:0] guess_count_o,
    output logic       win_o,
    output logic       game_over_o
);

    logic       load_q;
    logic       press;
    logic [1:0] peg_idx;

    // Rising edge of the button level
    assign press = load_i & ~load_q;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            load_q        <= 1'b0;
            peg_idx       <= '0;
            phase_o       <= CODE_ENTRY;
            code_o        <= '0;
            guess_o       <= '0;
            start_o       <= 1'b0;
            clear_o       <= 1'b0;
            guess_count_o <= '0;
            win_o         <= 1'b0;
            game_over_o   <= 1'b0;
        end else begin
            load_q  <= load_i;
            start_o <= 1'b0;
            clear_o <= 1'b0;

            case (phase_o)
                CODE_ENTRY: begin
                    if (press) begin
                        code_o.peg[peg_idx] <= colour_i;
                        peg_idx             <= peg_idx + 2'd1;
                        if (peg_idx == 2'(PEGS - 1)) begin
                            phase_o <= GUESS_ENTRY;
                        end
                    end
                end

                GUESS_ENTRY: begin
                    if (press) begin
                        guess_o.peg[peg_idx] <= colour_i;
                        peg_idx              <= peg_idx + 2'd1;
                        if (peg_idx == 2'(PEGS - 1)) begin // Row complete
                            phase_o <= SCORING;
                            start_o <= 1'b1;
                        end
                    end
                end

                // Button presses are dropped while the scorer runs
                SCORING: begin
                    if (done_i) begin
                        guess_count_o <= guess_count_o + 4'd1;
                        if (score_i.red == count_t'(PEGS)) begin
                            win_o   <= 1'b1;
                            phase_o <= GAME_END;
                        end else if (guess_count_o == 4'(MAX_GUESSES - 1)) begin
                            game_over_o <= 1'b1;
                            phase_o     <= GAME_END;
                        end else begin
                            phase_o <= GUESS_ENTRY;
                        end
                    end
                end

                GAME_END: begin
                    if (press) begin // New game, no peg written
                        code_o        <= '0;
                        guess_o       <= '0;
                        guess_count_o <= '0;
                        win_o         <= 1'b0;
                        game_over_o   <= 1'b0;
                        peg_idx       <= '0;
                        clear_o       <= 1'b1;
                        phase_o       <= CODE_ENTRY;
                    end
                end

                default: phase_o <= CODE_ENTRY;
            endcase
        end
    end

endmodule

// File: design/mastermind_scorer.sv
`timescale 1ns/1ns

module mastermind_scorer
    import mastermind_pkg::*;
(
    input  logic   clock,
    input  logic   resetn,
    input  logic   start_i,
    input  logic   clear_i,
    input  row_t   code_i,
    input  row_t   guess_i,
    output score_t score_o,
    output logic   done_o
);

    logic [PEGS-1:0] exact;
    count_t          exact_cnt;
    logic [PEGS-1:0] red_mask;
    logic [PEGS-1:0] claimed;   // Guess positions already used for a white
    count_t          red_cnt;
    count_t          white_cnt;
    logic            busy;
    logic [2:0]      pos;       // Code position being matched, PEGS when finished
    logic            stepping;
    logic [PEGS-1:0] avail;
    logic [PEGS-1:0] first_avail;

    always_comb begin
        exact_cnt = '0;
        for (int i = 0; i < PEGS; i++) begin
            exact[i]  = code_i.peg[i] == guess_i.peg[i];
            exact_cnt = exact_cnt + count_t'(exact[i]);
        end
    end

    // Free non-red guess pegs with the colour of the current code peg
    always_comb begin
        for (int j = 0; j < PEGS; j++) begin
            avail[j] = !red_mask[j] && !claimed[j]
                       && guess_i.peg[j] == code_i.peg[pos[1:0]];
        end
    end

    assign first_avail = avail & (~avail + 1'b1); // Lowest set bit only
    assign stepping    = busy && pos != 3'(PEGS);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy    <= 1'b0;
            pos     <= '0;
            done_o  <= 1'b0;
            score_o <= '0;
        end else begin
            done_o <= 1'b0;
            if (clear_i) begin
                score_o <= '0;
            end
            if (start_i) begin
                busy <= 1'b1;
                pos  <= '0;
            end else if (stepping) begin
                pos <= pos + 3'd1;
            end else if (busy) begin
                busy          <= 1'b0;
                done_o        <= 1'b1;
                score_o.red   <= red_cnt;
                score_o.white <= white_cnt;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start_i) begin
            red_mask  <= exact;
            red_cnt   <= exact_cnt;
            claimed   <= '0;
            white_cnt <= '0;
        end else if (stepping && !red_mask[pos[1:0]] && |avail) begin
            claimed   <= claimed | first_avail;
            white_cnt <= white_cnt + count_t'(1);
        end
    end

endmodule

// File: design/score_display.sv
`timescale 1ns/1ns

module score_display
    import mastermind_pkg::*;
    import seven_seg_pkg::*;
(
    input  logic                clock,
    input  row_t                guess_i,
    input  score_t              score_i,
    output segments_t [5:0]     hex_o
);

    // Digits 0 to 3 show the guess pegs, 4 red, 5 white
    always_ff @(posedge clock) begin
        for (int i = 0; i < PEGS; i++) begin
            hex_o[i] <= digit_segments({1'b0, guess_i.peg[i]});
        end
        hex_o[4] <= digit_segments({1'b0, score_i.red});
        hex_o[5] <= digit_segments({1'b0, score_i.white});
    end

endmodule

// File: design/mastermind_top.sv
`timescale 1ns/1ns

module mastermind_top
    import mastermind_pkg::*;
    import seven_seg_pkg::*;
#(
    parameter int MAX_GUESSES = 8
) (
    input  logic            clock,
    input  logic            resetn,
    input  logic            load_i,
    input  peg_t            colour_i,
    output phase_t          phase_o,
    output row_t            guess_o,
    output score_t          score_o,
    output logic [3:0]      guess_count_o,
    output logic            win_o,
    output logic            game_over_o,
    output segments_t [5:0] hex_o
);

    row_t code;
    logic start;
    logic clear;
    logic done;

    mastermind_entry #(
        .MAX_GUESSES(MAX_GUESSES)
    ) i_entry (
        .clock        (clock),
        .resetn       (resetn),
        .load_i       (load_i),
        .colour_i     (colour_i),
        .score_i      (score_o),
        .done_i       (done),
        .code_o       (code),
        .guess_o      (guess_o),
        .start_o      (start),
        .clear_o      (clear),
        .phase_o      (phase_o),
        .guess_count_o(guess_count_o),
        .win_o        (win_o),
        .game_over_o  (game_over_o)
    );

    mastermind_scorer i_scorer (
        .clock  (clock),
        .resetn (resetn),
        .start_i(start),
        .clear_i(clear),
        .code_i (code),
        .guess_i(guess_o),
        .score_o(score_o),
        .done_o (done)
    );

    score_display i_display (
        .clock  (clock),
        .guess_i(guess_o),
        .score_i(score_o),
        .hex_o  (hex_o)
    );

endmodule

// File: verification/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error");
endtask

// Red by position, white from colour counts over the non-red positions
function automatic score_t ref_score(input row_t code, input row_t guess);
    score_t s;
    int     code_cnt[8] = '{default: 0};
    int     guess_cnt[8] = '{default: 0};
    s = '0;
    for (int i = 0; i < PEGS; i++) begin
        if (code.peg[i] == guess.peg[i]) begin
            s.red = s.red + 3'd1;
        end else begin
            code_cnt[code.peg[i]]++;
            guess_cnt[guess.peg[i]]++;
        end
    end
    for (int c = 0; c < 8; c++) begin
        s.white = s.white + count_t'(code_cnt[c] < guess_cnt[c] ? code_cnt[c] : guess_cnt[c]);
    end
    return s;
endfunction

function automatic segments_t ref_segments(input logic [2:0] value);
    logic [6:0] lit; // Lit segments, a in bit 0
    case (value)
        3'd0: lit = 7'h3f;
        3'd1: lit = 7'h06;
        3'd2: lit = 7'h5b;
        3'd3: lit = 7'h4f;
        3'd4: lit = 7'h66;
        3'd5: lit = 7'h6d;
        3'd6: lit = 7'h7d;
        default: lit = 7'h07;
    endcase
    return ~lit; // Display is active low
endfunction

task automatic check_score(input score_t actual, input score_t expected, input string name);
    if (actual !== expected) begin
        $display("Mismatch at time %0t: %s red %0d white %0d, expected red %0d white %0d",
                 $time, name, actual.red, actual.white, expected.red, expected.white);
        abort_run();
    end
endtask

task automatic check_row(input row_t actual, input row_t expected, input string name);
    if (actual !== expected) begin
        $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, actual, expected);
        abort_run();
    end
endtask

task automatic check_phase(input phase_t actual, input phase_t expected, input string name);
    if (actual !== expected) begin
        $display("Mismatch at time %0t: %s is %s, expected %s",
                 $time, name, actual.name(), expected.name());
        abort_run();
    end
endtask

task automatic check_segments(input segments_t actual, input segments_t expected,
                              input string name);
    if (actual !== expected) begin
        $display("Mismatch at time %0t: %s is %b, expected %b", $time, name, actual, expected);
        abort_run();
    end
endtask

task automatic check_count(input logic [3:0] actual, input logic [3:0] expected,
                           input string name);
    if (actual !== expected) begin
        $display("Mismatch at time %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        abort_run();
    end
endtask

task automatic check_flag(input logic actual, input logic expected, input string name);
    if (actual !== expected) begin
        $display("Mismatch at time %0t: %s is %b, expected %b", $time, name, actual, expected);
        abort_run();
    end
endtask

`endif

// File: verification/tb_mastermind.sv
`timescale 1ns/1ns

module tb_mastermind
    import mastermind_pkg::*;
    import seven_seg_pkg::*;
();

    localparam int MAX_GUESSES   = 8;  // Same as the DUT default
    localparam int SCORE_LATENCY = 6;  // Fourth press to score_o
    localparam int PHASE_TIMEOUT = 50;

    logic            clock;
    logic            resetn;
    logic            load_i;
    peg_t            colour_i;
    phase_t          phase_o;
    row_t            guess_o;
    score_t          score_o;
    logic [3:0]      guess_count_o;
    logic            win_o;
    logic            game_over_o;
    segments_t [5:0] hex_o;

    row_t       code_row;
    row_t       exp_guess;
    logic [3:0] exp_count;
    score_t     last_score;
    row_t       prev_guess;
    score_t     prev_score;
    logic       monitor_on;

    `include "tb_checks.svh"

    mastermind_top i_dut (
        .clock        (clock),
        .resetn       (resetn),
        .load_i       (load_i),
        .colour_i     (colour_i),
        .phase_o      (phase_o),
        .guess_o      (guess_o),
        .score_o      (score_o),
        .guess_count_o(guess_count_o),
        .win_o        (win_o),
        .game_over_o  (game_over_o),
        .hex_o        (hex_o)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Display lags its source by one cycle
    always @(negedge clock) begin
        if (monitor_on) begin
            for (int i = 0; i < PEGS; i++) begin
                check_segments(hex_o[i], ref_segments(prev_guess.peg[i]),
                               $sformatf("hex_o[%0d]", i));
            end
            check_segments(hex_o[4], ref_segments(prev_score.red), "hex_o[4]");
            check_segments(hex_o[5], ref_segments(prev_score.white), "hex_o[5]");
        end
        prev_guess = guess_o;
        prev_score = score_o;
        monitor_on = resetn;
    end

    task automatic press_peg(input peg_t colour, input int hold);
        @(posedge clock);
        load_i   <= 1'b1;
        colour_i <= colour;
        repeat (hold) @(posedge clock); // First edge takes the press
        load_i <= 1'b0;
        repeat (2) @(posedge clock);
    endtask

    task automatic wait_phase(input phase_t target, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (phase_o !== target) begin
            if (cycles == limit) begin
                $display("Timeout at time %0t: phase_o never reached %s", $time, target.name());
                abort_run();
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    function automatic row_t random_row(input bit narrow);
        row_t r;
        for (int i = 0; i < PEGS; i++) begin
            r.peg[i] = narrow ? peg_t'($urandom % 3) : peg_t'($urandom % 8); // Narrow repeats
        end
        return r;
    endfunction

    function automatic row_t losing_row(input bit narrow);
        row_t r;
        r = random_row(narrow);
        if (r == code_row) begin
            r.peg[0] = r.peg[0] + 3'd1;
        end
        return r;
    endfunction

    task automatic enter_code(input row_t code);
        for (int i = 0; i < PEGS; i++) begin
            press_peg(code.peg[i], 1 + int'($urandom % 3));
            @(negedge clock);
            check_phase(phase_o, (i == PEGS - 1) ? GUESS_ENTRY : CODE_ENTRY, "phase_o");
        end
        code_row = code;
    endtask

    task automatic play_guess(input row_t guess, input bit extra_press);
        int     hold;
        int     edges;  // Rising edges since the fourth press was taken
        score_t expected;
        expected = ref_score(code_row, guess);
        for (int i = 0; i < PEGS; i++) begin
            hold = (extra_press && i == PEGS - 1) ? 1 : 1 + int'($urandom % 3);
            press_peg(guess.peg[i], hold);
            exp_guess.peg[i] = guess.peg[i];
            @(negedge clock);
            check_row(guess_o, exp_guess, "guess_o");
        end
        edges = hold + 1;
        if (extra_press) begin
            press_peg(~guess.peg[0], 1); // Taken while scoring
            edges = edges + 4;
        end
        if (edges < SCORE_LATENCY) begin
            repeat (SCORE_LATENCY - 1 - edges) @(posedge clock);
            @(negedge clock);
            check_score(score_o, last_score, "score_o"); // Old score one cycle before
        end
        @(negedge clock);
        check_phase(phase_o, SCORING, "phase_o");
        check_row(guess_o, exp_guess, "guess_o");
        check_score(score_o, expected, "score_o");
        last_score = expected;
        @(posedge clock);
        @(negedge clock);
        exp_count = exp_count + 4'd1;
        check_count(guess_count_o, exp_count, "guess_count_o");
        if (expected.red == count_t'(PEGS)) begin
            check_phase(phase_o, GAME_END, "phase_o");
            check_flag(win_o, 1'b1, "win_o");
            check_flag(game_over_o, 1'b0, "game_over_o");
        end else if (exp_count == 4'(MAX_GUESSES)) begin
            check_phase(phase_o, GAME_END, "phase_o");
            check_flag(game_over_o, 1'b1, "game_over_o");
            check_flag(win_o, 1'b0, "win_o");
        end else begin
            check_phase(phase_o, GUESS_ENTRY, "phase_o");
            check_flag(win_o, 1'b0, "win_o");
            check_flag(game_over_o, 1'b0, "game_over_o");
        end
    endtask

    task automatic start_new_game();
        press_peg(peg_t'($urandom % 8), 1 + int'($urandom % 3));
        wait_phase(CODE_ENTRY, PHASE_TIMEOUT);
        check_count(guess_count_o, 4'd0, "guess_count_o");
        check_flag(win_o, 1'b0, "win_o");
        check_flag(game_over_o, 1'b0, "game_over_o");
        check_score(score_o, '0, "score_o");
        check_row(guess_o, '0, "guess_o");
        exp_guess  = '0;
        exp_count  = '0;
        last_score = '0;
    endtask

    initial begin
        void'($urandom(69));
        resetn     = 1'b0;
        load_i     = 1'b0;
        colour_i   = '0;
        monitor_on = 1'b0;
        exp_guess  = '0;
        exp_count  = '0;
        last_score = '0;
        code_row   = '0;
        repeat (16) @(posedge clock);
        resetn <= 1'b1;

        wait_phase(CODE_ENTRY, PHASE_TIMEOUT);
        @(negedge clock);
        check_score(score_o, '0, "score_o");
        check_count(guess_count_o, 4'd0, "guess_count_o");
        check_flag(win_o, 1'b0, "win_o");
        check_flag(game_over_o, 1'b0, "game_over_o");
        for (int i = 0; i < 6; i++) begin
            check_segments(hex_o[i], ref_segments(3'd0), $sformatf("hex_o[%0d]", i));
        end

        // Game won on the last allowed guess
        enter_code(random_row(1'b0));
        for (int g = 0; g < MAX_GUESSES - 1; g++) begin
            play_guess(losing_row(g[0]), 1'b0);
        end
        play_guess(code_row, 1'b0);
        start_new_game();

        // Game lost, with presses during scoring
        enter_code(random_row(1'b1));
        for (int g = 0; g < MAX_GUESSES; g++) begin
            play_guess(losing_row(1'b1), !g[0]);
        end
        start_new_game();

        enter_code(random_row(1'b1));
        for (int g = 0; g < 3; g++) begin
            play_guess(losing_row(1'b1), 1'b0);
        end
        play_guess(code_row, 1'b1);

        repeat (4) @(posedge clock);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: list.f
+incdir+verification
design/mastermind_pkg.sv
design/seven_seg_pkg.sv
design/mastermind_entry.sv
design/mastermind_scorer.sv
design/score_display.sv
design/mastermind_top.sv
verification/tb_mastermind.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary -Wno-fatal --top-module tb_mastermind -f list.f -Mdir obj_dir
	-./obj_dir/Vtb_mastermind > sim.log 2>&1
	@cat sim.log
	@grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
